// ==== src/proc_pkg.sv ====
// Word and register select types, opcode and funct encodings, forwarding selects
`default_nettype none

package proc_pkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0] reg_sel_t;

	// Major opcode in bits 15 to 11
	typedef enum logic [4:0] {
		op_halt = 5'b00000,
		op_nop  = 5'b00001,
		op_addi = 5'b01000,
		op_beqz = 5'b01100,
		op_bnez = 5'b01101,
		op_st   = 5'b10000,
		op_ld   = 5'b10001,
		op_lbi  = 5'b11000,
		op_alu  = 5'b11011
	} opcode_t;

	// Register ALU operation in bits 1 to 0
	typedef enum logic [1:0] {
		funct_add  = 2'b00,
		funct_sub  = 2'b01,
		funct_xor  = 2'b10,
		funct_andn = 2'b11
	} funct_t;

	// Operand source for the execute stage
	typedef enum logic [1:0] {
		fwd_none = 2'b00,
		fwd_mem  = 2'b01,
		fwd_wb   = 2'b10
	} fwd_sel_t;

	// NOP with all other fields zero
	localparam word_t instr_nop = 16'h0800;

	// Two bytes per instruction
	localparam word_t pc_step = 16'd2;

	localparam int num_regs = 8;

endpackage

`default_nettype wire

// ==== src/fetch_stage.sv ====
// Fetch stage with the PC and the fetch/decode register
`default_nettype none

module fetch_stage (
	input  wire                   clk,
	input  wire                   reset,
	output proc_pkg::word_t       imem_addr,
	input  wire proc_pkg::word_t  imem_data,
	input  wire                   stall,
	input  wire                   flush,
	input  wire                   halt_seen,
	input  wire                   branch_taken,
	input  wire proc_pkg::word_t  branch_target,
	output proc_pkg::word_t       instr,
	output proc_pkg::word_t       pc_next
);

	proc_pkg::word_t pc;
	proc_pkg::word_t pc_plus;

	assign pc_plus = pc + proc_pkg::pc_step;
	assign imem_addr = pc;

	// Taken branch wins over stall and halt
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (branch_taken) begin
			pc <= branch_target;
		end else if (!stall && !halt_seen) begin
			pc <= pc_plus;
		end
	end

	// Anything fetched behind a halt is dropped
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			instr <= proc_pkg::instr_nop;
		end else if (!stall) begin
			instr <= halt_seen ? proc_pkg::instr_nop : imem_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			pc_next <= pc_plus;
		end
	end

	a_pc_even: assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0)
		else $error("PC is odd");

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
// Decode stage with control decode, immediate extension, illegal opcode flag, decode/execute register
`default_nettype none

module decode_stage (
	input  wire                   clk,
	input  wire                   reset,
	input  wire proc_pkg::word_t  instr,
	input  wire proc_pkg::word_t  pc_next,
	input  wire                   stall,
	input  wire                   flush,
	output proc_pkg::reg_sel_t    rs_sel,
	output proc_pkg::reg_sel_t    rt_sel,
	input  wire proc_pkg::word_t  rs_data,
	input  wire proc_pkg::word_t  rt_data,
	output proc_pkg::opcode_t     ex_opcode,
	output proc_pkg::funct_t      ex_funct,
	output proc_pkg::reg_sel_t    ex_rs_sel,
	output proc_pkg::reg_sel_t    ex_rt_sel,
	output proc_pkg::reg_sel_t    ex_dest,
	output logic                  ex_reg_write,
	output logic                  ex_mem_read,
	output logic                  ex_mem_write,
	output logic                  ex_halt,
	output proc_pkg::word_t       ex_a,
	output proc_pkg::word_t       ex_b,
	output proc_pkg::word_t       ex_imm,
	output proc_pkg::word_t       ex_pc_next,
	output logic                  halt_seen,
	output logic                  err
);

	proc_pkg::opcode_t  opcode;
	proc_pkg::reg_sel_t dest;
	proc_pkg::word_t    imm5_ext;
	proc_pkg::word_t    imm8_ext;
	logic               use_imm8;
	logic               reg_write;
	logic               mem_read;
	logic               mem_write;
	logic               is_halt;
	logic               illegal;
	logic               bubble;
	logic               halt_latched;

	assign opcode = proc_pkg::opcode_t'(instr[15:11]);
	assign rs_sel = instr[10:8];
	assign rt_sel = instr[7:5];
	assign imm5_ext = {{11{instr[4]}}, instr[4:0]};
	assign imm8_ext = {{8{instr[7]}}, instr[7:0]};
	assign bubble = stall || flush;

	always_comb begin
		dest = instr[4:2];
		use_imm8 = 1'b0;
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		is_halt = 1'b0;
		illegal = 1'b0;
		case (opcode)
			proc_pkg::op_halt: is_halt = 1'b1;
			proc_pkg::op_nop: begin
				// No state change
			end
			proc_pkg::op_alu: reg_write = 1'b1;
			proc_pkg::op_addi: begin
				dest = instr[7:5];
				reg_write = 1'b1;
			end
			proc_pkg::op_ld: begin
				dest = instr[7:5];
				reg_write = 1'b1;
				mem_read = 1'b1;
			end
			proc_pkg::op_st: mem_write = 1'b1;
			proc_pkg::op_lbi: begin
				dest = instr[10:8];
				reg_write = 1'b1;
				use_imm8 = 1'b1;
			end
			proc_pkg::op_beqz, proc_pkg::op_bnez: use_imm8 = 1'b1;
			default: illegal = 1'b1;
		endcase
	end

	// Control half of decode/execute takes a bubble on stall or flush
	always_ff @(posedge clk) begin
		if (reset || bubble) begin
			ex_opcode <= proc_pkg::op_nop;
			ex_rs_sel <= '0;
			ex_rt_sel <= '0;
			ex_dest <= '0;
			ex_reg_write <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_halt <= 1'b0;
		end else begin
			ex_opcode <= opcode;
			ex_rs_sel <= rs_sel;
			ex_rt_sel <= rt_sel;
			ex_dest <= dest;
			ex_reg_write <= reg_write;
			ex_mem_read <= mem_read;
			ex_mem_write <= mem_write;
			ex_halt <= is_halt;
		end
	end

	always_ff @(posedge clk) begin
		ex_funct <= proc_pkg::funct_t'(instr[1:0]);
		ex_a <= rs_data;
		ex_b <= rt_data;
		ex_imm <= use_imm8 ? imm8_ext : imm5_ext;
		ex_pc_next <= pc_next;
	end

	// Halt holds fetch from the moment it is decoded
	always_ff @(posedge clk) begin
		if (reset) begin
			halt_latched <= 1'b0;
		end else if (is_halt && !bubble) begin
			halt_latched <= 1'b1;
		end
	end

	assign halt_seen = halt_latched || is_halt;

	always_ff @(posedge clk) begin
		if (reset) begin
			err <= 1'b0;
		end else if (illegal && !flush) begin
			err <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
// Eight entry register file with write-before-read bypass
`default_nettype none

module reg_file (
	input  wire                      clk,
	input  wire                      reset,
	input  wire proc_pkg::reg_sel_t  rs_sel,
	input  wire proc_pkg::reg_sel_t  rt_sel,
	output proc_pkg::word_t          rs_data,
	output proc_pkg::word_t          rt_data,
	input  wire proc_pkg::reg_sel_t  wb_sel,
	input  wire proc_pkg::word_t     wb_data,
	input  wire                      wb_en
);

	proc_pkg::word_t regs [proc_pkg::num_regs];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < proc_pkg::num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en) begin
			regs[wb_sel] <= wb_data;
		end
	end

	// Same cycle write shows on the read port
	assign rs_data = (wb_en && wb_sel == rs_sel) ? wb_data : regs[rs_sel];
	assign rt_data = (wb_en && wb_sel == rt_sel) ? wb_data : regs[rt_sel];

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
// Execute stage with operand forwarding, ALU, branch resolution and execute/memory register
`default_nettype none

module execute_stage (
	input  wire                      clk,
	input  wire                      reset,
	input  wire proc_pkg::opcode_t   ex_opcode,
	input  wire proc_pkg::funct_t    ex_funct,
	input  wire proc_pkg::reg_sel_t  ex_dest,
	input  wire                      ex_reg_write,
	input  wire                      ex_mem_read,
	input  wire                      ex_mem_write,
	input  wire                      ex_halt,
	input  wire proc_pkg::word_t     ex_a,
	input  wire proc_pkg::word_t     ex_b,
	input  wire proc_pkg::word_t     ex_imm,
	input  wire proc_pkg::word_t     ex_pc_next,
	input  wire proc_pkg::fwd_sel_t  fwd_a,
	input  wire proc_pkg::fwd_sel_t  fwd_b,
	input  wire proc_pkg::word_t     mem_fwd_data,
	input  wire proc_pkg::word_t     wb_fwd_data,
	output logic                     branch_taken,
	output proc_pkg::word_t          branch_target,
	output proc_pkg::word_t          alu_result,
	output proc_pkg::word_t          store_data,
	output proc_pkg::reg_sel_t       mem_dest,
	output logic                     mem_reg_write,
	output logic                     mem_read,
	output logic                     mem_write,
	output logic                     mem_halt
);

	proc_pkg::word_t op_a;
	proc_pkg::word_t op_b;
	proc_pkg::word_t result;
	logic            rs_zero;

	function automatic proc_pkg::word_t pick(input proc_pkg::fwd_sel_t sel,
		input proc_pkg::word_t reg_val, input proc_pkg::word_t mem_val,
		input proc_pkg::word_t wb_val);
		case (sel)
			proc_pkg::fwd_mem: return mem_val;
			proc_pkg::fwd_wb: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign op_a = pick(fwd_a, ex_a, mem_fwd_data, wb_fwd_data);
	assign op_b = pick(fwd_b, ex_b, mem_fwd_data, wb_fwd_data);

	always_comb begin
		case (ex_opcode)
			proc_pkg::op_alu: begin
				case (ex_funct)
					proc_pkg::funct_add: result = op_a + op_b;
					proc_pkg::funct_sub: result = op_a - op_b;
					proc_pkg::funct_xor: result = op_a ^ op_b;
					default: result = op_a & ~op_b;
				endcase
			end
			proc_pkg::op_lbi: result = ex_imm;
			// Add immediate and load/store address
			default: result = op_a + ex_imm;
		endcase
	end

	// Branch tests the forwarded rs
	assign rs_zero = (op_a == '0);
	assign branch_taken = (ex_opcode == proc_pkg::op_beqz && rs_zero)
		|| (ex_opcode == proc_pkg::op_bnez && !rs_zero);
	assign branch_target = ex_pc_next + ex_imm;

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_dest <= '0;
			mem_reg_write <= 1'b0;
			mem_read <= 1'b0;
			mem_write <= 1'b0;
			mem_halt <= 1'b0;
		end else begin
			mem_dest <= ex_dest;
			mem_reg_write <= ex_reg_write;
			mem_read <= ex_mem_read;
			mem_write <= ex_mem_write;
			mem_halt <= ex_halt;
		end
	end

	always_ff @(posedge clk) begin
		alu_result <= result;
		store_data <= op_b;
	end

	a_mem_excl: assert property (@(posedge clk) disable iff (reset) !(mem_read && mem_write))
		else $error("Load and store in the same slot");

endmodule

`default_nettype wire

// ==== src/hazard_unit.sv ====
// Forwarding selects, load-use stall and branch flush
`default_nettype none

module hazard_unit (
	input  wire proc_pkg::reg_sel_t  id_rs_sel,
	input  wire proc_pkg::reg_sel_t  id_rt_sel,
	input  wire proc_pkg::reg_sel_t  ex_rs_sel,
	input  wire proc_pkg::reg_sel_t  ex_rt_sel,
	input  wire                      ex_mem_read,
	input  wire proc_pkg::reg_sel_t  ex_dest,
	input  wire proc_pkg::reg_sel_t  mem_dest,
	input  wire proc_pkg::reg_sel_t  wb_dest,
	input  wire                      mem_reg_write,
	input  wire                      wb_reg_write,
	input  wire                      branch_taken,
	output proc_pkg::fwd_sel_t       fwd_a,
	output proc_pkg::fwd_sel_t       fwd_b,
	output logic                     stall,
	output logic                     flush
);

	logic load_use;

	// Younger producer in execute/memory comes first
	function automatic proc_pkg::fwd_sel_t source_of(input proc_pkg::reg_sel_t src);
		if (mem_reg_write && mem_dest == src) begin
			return proc_pkg::fwd_mem;
		end
		if (wb_reg_write && wb_dest == src) begin
			return proc_pkg::fwd_wb;
		end
		return proc_pkg::fwd_none;
	endfunction

	always_comb begin
		fwd_a = source_of(ex_rs_sel);
		fwd_b = source_of(ex_rt_sel);
	end

	assign load_use = ex_mem_read && (ex_dest == id_rs_sel || ex_dest == id_rt_sel);

	// Flush discards the stalled instruction anyway
	assign flush = branch_taken;
	assign stall = load_use && !branch_taken;

endmodule

`default_nettype wire

// ==== src/writeback_stage.sv ====
// Data memory port, memory/writeback register, writeback data and halted flag
`default_nettype none

module writeback_stage (
	input  wire                      clk,
	input  wire                      reset,
	input  wire proc_pkg::word_t     alu_result,
	input  wire proc_pkg::word_t     store_data,
	input  wire proc_pkg::reg_sel_t  mem_dest,
	input  wire                      mem_reg_write,
	input  wire                      mem_read,
	input  wire                      mem_write,
	input  wire                      mem_halt,
	output logic                     dmem_en,
	output logic                     dmem_wr,
	output proc_pkg::word_t          dmem_addr,
	output proc_pkg::word_t          dmem_wdata,
	input  wire proc_pkg::word_t     dmem_rdata,
	output proc_pkg::reg_sel_t       wb_sel,
	output proc_pkg::word_t          wb_data,
	output logic                     wb_en,
	output proc_pkg::word_t          mem_fwd_data,
	output logic                     halted
);

	assign dmem_en = mem_read || mem_write;
	assign dmem_wr = mem_write;
	assign dmem_addr = alu_result;
	assign dmem_wdata = store_data;

	// Loads pick the memory word here
	assign mem_fwd_data = mem_read ? dmem_rdata : alu_result;

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_sel <= '0;
			wb_en <= 1'b0;
			halted <= 1'b0;
		end else begin
			wb_sel <= mem_dest;
			wb_en <= mem_reg_write;
			if (mem_halt) begin
				halted <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		wb_data <= mem_fwd_data;
	end

endmodule

`default_nettype wire

// ==== src/proc.sv ====
// Five stage processor top level connecting the stages, register file and hazard unit
`default_nettype none

module proc (
	input  wire                   clk,
	input  wire                   reset,
	output proc_pkg::word_t       imem_addr,
	input  wire proc_pkg::word_t  imem_data,
	output logic                  dmem_en,
	output logic                  dmem_wr,
	output proc_pkg::word_t       dmem_addr,
	output proc_pkg::word_t       dmem_wdata,
	input  wire proc_pkg::word_t  dmem_rdata,
	output logic                  halted,
	output logic                  err
);

	proc_pkg::word_t    instr;
	proc_pkg::word_t    pc_next;
	proc_pkg::word_t    rs_data;
	proc_pkg::word_t    rt_data;
	proc_pkg::word_t    ex_a;
	proc_pkg::word_t    ex_b;
	proc_pkg::word_t    ex_imm;
	proc_pkg::word_t    ex_pc_next;
	proc_pkg::word_t    branch_target;
	proc_pkg::word_t    alu_result;
	proc_pkg::word_t    store_data;
	proc_pkg::word_t    wb_data;
	proc_pkg::word_t    mem_fwd_data;
	proc_pkg::reg_sel_t rs_sel;
	proc_pkg::reg_sel_t rt_sel;
	proc_pkg::reg_sel_t ex_rs_sel;
	proc_pkg::reg_sel_t ex_rt_sel;
	proc_pkg::reg_sel_t ex_dest;
	proc_pkg::reg_sel_t mem_dest;
	proc_pkg::reg_sel_t wb_sel;
	proc_pkg::opcode_t  ex_opcode;
	proc_pkg::funct_t   ex_funct;
	proc_pkg::fwd_sel_t fwd_a;
	proc_pkg::fwd_sel_t fwd_b;
	logic               stall;
	logic               flush;
	logic               halt_seen;
	logic               branch_taken;
	logic               ex_reg_write;
	logic               ex_mem_read;
	logic               ex_mem_write;
	logic               ex_halt;
	logic               mem_reg_write;
	logic               mem_read;
	logic               mem_write;
	logic               mem_halt;
	logic               wb_en;

	fetch_stage u_fetch (
		.clk           (clk),
		.reset         (reset),
		.imem_addr     (imem_addr),
		.imem_data     (imem_data),
		.stall         (stall),
		.flush         (flush),
		.halt_seen     (halt_seen),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.instr         (instr),
		.pc_next       (pc_next)
	);

	decode_stage u_decode (
		.clk          (clk),
		.reset        (reset),
		.instr        (instr),
		.pc_next      (pc_next),
		.stall        (stall),
		.flush        (flush),
		.rs_sel       (rs_sel),
		.rt_sel       (rt_sel),
		.rs_data      (rs_data),
		.rt_data      (rt_data),
		.ex_opcode    (ex_opcode),
		.ex_funct     (ex_funct),
		.ex_rs_sel    (ex_rs_sel),
		.ex_rt_sel    (ex_rt_sel),
		.ex_dest      (ex_dest),
		.ex_reg_write (ex_reg_write),
		.ex_mem_read  (ex_mem_read),
		.ex_mem_write (ex_mem_write),
		.ex_halt      (ex_halt),
		.ex_a         (ex_a),
		.ex_b         (ex_b),
		.ex_imm       (ex_imm),
		.ex_pc_next   (ex_pc_next),
		.halt_seen    (halt_seen),
		.err          (err)
	);

	reg_file u_reg_file (
		.clk     (clk),
		.reset   (reset),
		.rs_sel  (rs_sel),
		.rt_sel  (rt_sel),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.wb_sel  (wb_sel),
		.wb_data (wb_data),
		.wb_en   (wb_en)
	);

	execute_stage u_execute (
		.clk           (clk),
		.reset         (reset),
		.ex_opcode     (ex_opcode),
		.ex_funct      (ex_funct),
		.ex_dest       (ex_dest),
		.ex_reg_write  (ex_reg_write),
		.ex_mem_read   (ex_mem_read),
		.ex_mem_write  (ex_mem_write),
		.ex_halt       (ex_halt),
		.ex_a          (ex_a),
		.ex_b          (ex_b),
		.ex_imm        (ex_imm),
		.ex_pc_next    (ex_pc_next),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b),
		.mem_fwd_data  (mem_fwd_data),
		.wb_fwd_data   (wb_data),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.alu_result    (alu_result),
		.store_data    (store_data),
		.mem_dest      (mem_dest),
		.mem_reg_write (mem_reg_write),
		.mem_read      (mem_read),
		.mem_write     (mem_write),
		.mem_halt      (mem_halt)
	);

	hazard_unit u_hazard (
		.id_rs_sel     (rs_sel),
		.id_rt_sel     (rt_sel),
		.ex_rs_sel     (ex_rs_sel),
		.ex_rt_sel     (ex_rt_sel),
		.ex_mem_read   (ex_mem_read),
		.ex_dest       (ex_dest),
		.mem_dest      (mem_dest),
		.wb_dest       (wb_sel),
		.mem_reg_write (mem_reg_write),
		.wb_reg_write  (wb_en),
		.branch_taken  (branch_taken),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b),
		.stall         (stall),
		.flush         (flush)
	);

	writeback_stage u_writeback (
		.clk           (clk),
		.reset         (reset),
		.alu_result    (alu_result),
		.store_data    (store_data),
		.mem_dest      (mem_dest),
		.mem_reg_write (mem_reg_write),
		.mem_read      (mem_read),
		.mem_write     (mem_write),
		.mem_halt      (mem_halt),
		.dmem_en       (dmem_en),
		.dmem_wr       (dmem_wr),
		.dmem_addr     (dmem_addr),
		.dmem_wdata    (dmem_wdata),
		.dmem_rdata    (dmem_rdata),
		.wb_sel        (wb_sel),
		.wb_data       (wb_data),
		.wb_en         (wb_en),
		.mem_fwd_data  (mem_fwd_data),
		.halted        (halted)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
// Testbench clock and reset generator with restart request
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic reset,
	input  wire  restart
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int half_period = 5;
	localparam int reset_cycles = 10;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// Reset held for ten rising edges and raised again on each restart
	initial begin
		reset = 1'b1;
		forever begin
			repeat (reset_cycles) @(posedge clk);
			#1;
			reset = 1'b0;
			@(posedge restart);
			reset = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== testbench/proc_tb.sv ====
// Processor testbench with memory models, LCG, directed tests, port monitor and watchdog
`default_nettype none

module proc_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// Sum of all program lengths below
	localparam int total_prog_words = 56;
	localparam int watchdog_cycles = total_prog_words * 20;
	localparam int hold_cycles = 8;

	logic            clk;
	logic            reset;
	logic            restart;
	proc_pkg::word_t imem_addr;
	proc_pkg::word_t imem_data;
	logic            dmem_en;
	logic            dmem_wr;
	proc_pkg::word_t dmem_addr;
	proc_pkg::word_t dmem_wdata;
	proc_pkg::word_t dmem_rdata;
	logic            halted;
	logic            err;

	proc_pkg::word_t imem [256];
	proc_pkg::word_t dmem [256];
	proc_pkg::word_t prog [$];
	proc_pkg::word_t log_addr [$];
	proc_pkg::word_t log_data [$];
	proc_pkg::word_t exp_addr [$];
	proc_pkg::word_t exp_data [$];
	logic [31:0]     lcg_state;
	int              errors;
	int              port_errors;
	int              checks;
	logic            reset_prev;
	logic            halted_q;

	tb_clock_gen u_clock (
		.clk     (clk),
		.reset   (reset),
		.restart (restart)
	);

	proc u_dut (
		.clk        (clk),
		.reset      (reset),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_en    (dmem_en),
		.dmem_wr    (dmem_wr),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_rdata (dmem_rdata),
		.halted     (halted),
		.err        (err)
	);

	// Both memories are word arrays indexed by the byte address
	assign imem_data = imem[imem_addr[8:1]];
	assign dmem_rdata = (dmem_en && !dmem_wr) ? dmem[dmem_addr[8:1]] : 16'h0000;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic proc_pkg::word_t fill_word(input logic [7:0] idx);
		return {idx ^ 8'ha5, idx};
	endfunction

	function automatic proc_pkg::word_t alu_instr(input int rs, input int rt, input int rd,
		input proc_pkg::funct_t f);
		return {proc_pkg::op_alu, rs[2:0], rt[2:0], rd[2:0], f};
	endfunction

	function automatic proc_pkg::word_t imm_instr(input proc_pkg::opcode_t op, input int rs,
		input int rt, input int imm);
		return {op, rs[2:0], rt[2:0], imm[4:0]};
	endfunction

	function automatic proc_pkg::word_t lbi_instr(input int rs, input int imm);
		return {proc_pkg::op_lbi, rs[2:0], imm[7:0]};
	endfunction

	function automatic proc_pkg::word_t branch_instr(input proc_pkg::opcode_t op, input int rs,
		input int disp);
		return {op, rs[2:0], disp[7:0]};
	endfunction

	function automatic proc_pkg::word_t halt_instr();
		return {proc_pkg::op_halt, 11'b0};
	endfunction

	task automatic put_data(input proc_pkg::word_t addr, input proc_pkg::word_t value);
		dmem[addr[8:1]] = value;
	endtask

	task automatic expect_store(input proc_pkg::word_t addr, input proc_pkg::word_t value);
		exp_addr.push_back(addr);
		exp_data.push_back(value);
	endtask

	task automatic start_test(input string name);
		$display("Test: %s", name);
		for (int i = 0; i < 256; i++) begin
			dmem[i[7:0]] = fill_word(i[7:0]);
		end
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic pulse_reset();
		@(posedge clk);
		#1;
		restart = 1'b1;
		@(posedge clk);
		#1;
		restart = 1'b0;
		while (reset !== 1'b0) @(negedge clk);
	endtask

	task automatic wait_halted(input int max_cycles);
		int n;
		n = 0;
		while (halted !== 1'b1 && n < max_cycles) begin
			@(negedge clk);
			n++;
		end
		checks++;
		if (halted !== 1'b1) begin
			errors++;
			$display("Error: halted did not rise within %0d cycles", max_cycles);
		end
	endtask

	// Load the program behind a HALT fill, reset, run to halt and linger
	task automatic run_program();
		int limit;
		limit = prog.size() * 20;
		for (int i = 0; i < 256; i++) begin
			imem[i[7:0]] = halt_instr();
		end
		for (int i = 0; i < prog.size(); i++) begin
			imem[i[7:0]] = prog[i];
		end
		log_addr.delete();
		log_data.delete();
		pulse_reset();
		wait_halted(limit);
		repeat (hold_cycles) @(negedge clk);
	endtask

	task automatic match_store_log();
		checks++;
		if (log_addr.size() != exp_addr.size()) begin
			errors++;
			$display("Error: %0d stores seen on the data port, %0d expected",
				log_addr.size(), exp_addr.size());
		end
		for (int i = 0; i < exp_addr.size() && i < log_addr.size(); i++) begin
			checks++;
			if (log_addr[i] !== exp_addr[i]) begin
				errors++;
				$display("FAIL dmem_addr store %0d: expected %h, got %h", i, exp_addr[i],
					log_addr[i]);
			end
			if (log_data[i] !== exp_data[i]) begin
				errors++;
				$display("FAIL dmem_wdata store %0d: expected %h, got %h", i, exp_data[i],
					log_data[i]);
			end
		end
	endtask

	task automatic mem_word_equals(input proc_pkg::word_t addr, input proc_pkg::word_t expected);
		checks++;
		if (dmem[addr[8:1]] !== expected) begin
			errors++;
			$display("FAIL dmem[%h]: expected %h, got %h", addr, expected, dmem[addr[8:1]]);
		end
	endtask

	task automatic fill_intact(input proc_pkg::word_t addr);
		mem_word_equals(addr, fill_word(addr[8:1]));
	endtask

	task automatic flag_equals(input string name, input logic got, input logic expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("FAIL %s: expected %h, got %h", name, expected, got);
		end
	endtask

	task automatic reset_state_is(input string name, input proc_pkg::word_t got,
		input proc_pkg::word_t expected);
		if (got !== expected) begin
			port_errors++;
			$display("FAIL %s during reset: expected %h, got %h", name, expected, got);
		end
	endtask

	// Each result feeds the next instruction directly
	task automatic alu_forwarding();
		logic [31:0]     r;
		proc_pkg::word_t a;
		proc_pkg::word_t b;
		proc_pkg::word_t s3;
		proc_pkg::word_t s4;
		proc_pkg::word_t s5;
		proc_pkg::word_t s6;
		start_test("dependent ALU chain");
		r = next_rand();
		a = r[31:16];
		r = next_rand();
		b = r[31:16];
		put_data(16'h0000, a);
		put_data(16'h0002, b);
		prog.push_back(imm_instr(proc_pkg::op_ld, 0, 1, 0));
		prog.push_back(imm_instr(proc_pkg::op_ld, 0, 2, 2));
		prog.push_back(lbi_instr(7, 64));
		prog.push_back(alu_instr(1, 2, 3, proc_pkg::funct_add));
		prog.push_back(alu_instr(3, 1, 4, proc_pkg::funct_sub));
		prog.push_back(alu_instr(4, 3, 5, proc_pkg::funct_xor));
		prog.push_back(alu_instr(5, 4, 6, proc_pkg::funct_andn));
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 3, 0));
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 4, 2));
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 5, 4));
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 6, 6));
		prog.push_back(halt_instr());
		run_program();
		s3 = a + b;
		s4 = s3 - a;
		s5 = s4 ^ s3;
		s6 = s5 & ~s4;
		expect_store(16'd64, s3);
		expect_store(16'd66, s4);
		expect_store(16'd68, s5);
		expect_store(16'd70, s6);
		match_store_log();
		mem_word_equals(16'd64, s3);
		mem_word_equals(16'd66, s4);
		mem_word_equals(16'd68, s5);
		mem_word_equals(16'd70, s6);
		flag_equals("err", err, 1'b0);
	endtask

	task automatic immediate_extension();
		logic [31:0] r;
		int          neg5;
		int          pos5;
		int          neg8;
		int          neg5b;
		start_test("immediate sign extension");
		r = next_rand();
		neg5 = int'(r[3:0]) - 16;
		pos5 = int'(r[7:4] | 4'd1);
		neg8 = int'(r[14:8]) - 128;
		neg5b = int'(r[19:16]) - 16;
		prog.push_back(lbi_instr(7, 64));
		prog.push_back(imm_instr(proc_pkg::op_addi, 0, 1, neg5));
		prog.push_back(imm_instr(proc_pkg::op_addi, 1, 2, pos5));
		prog.push_back(lbi_instr(3, neg8));
		prog.push_back(imm_instr(proc_pkg::op_addi, 3, 4, neg5b));
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 1, 0));
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 2, 2));
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 3, 4));
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 4, 6));
		prog.push_back(halt_instr());
		run_program();
		expect_store(16'd64, 16'(neg5));
		expect_store(16'd66, 16'(neg5 + pos5));
		expect_store(16'd68, 16'(neg8));
		expect_store(16'd70, 16'(neg8 + neg5b));
		match_store_log();
		flag_equals("err", err, 1'b0);
	endtask

	// Loaded value consumed at once, then stored and read back
	task automatic load_use_stall();
		logic [31:0]     r;
		proc_pkg::word_t v;
		proc_pkg::word_t v3;
		start_test("load-use stall and memory round trip");
		r = next_rand();
		v = r[31:16];
		put_data(16'h0000, v);
		prog.push_back(lbi_instr(7, 64));
		prog.push_back(imm_instr(proc_pkg::op_ld, 0, 1, 0));
		prog.push_back(imm_instr(proc_pkg::op_addi, 1, 2, 3));
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 2, 0));
		prog.push_back(imm_instr(proc_pkg::op_ld, 7, 3, 0));
		prog.push_back(alu_instr(3, 1, 4, proc_pkg::funct_xor));
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 4, 2));
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 3, 4));
		prog.push_back(halt_instr());
		run_program();
		v3 = v + 16'd3;
		expect_store(16'd64, v3);
		expect_store(16'd66, v3 ^ v);
		expect_store(16'd68, v3);
		match_store_log();
		mem_word_equals(16'd68, v3);
		flag_equals("err", err, 1'b0);
	endtask

	task automatic branch_paths();
		start_test("branches taken and not taken");
		prog.push_back(lbi_instr(7, 64));
		prog.push_back(lbi_instr(2, 5));
		prog.push_back(branch_instr(proc_pkg::op_beqz, 0, 4));
		// Shadow of the taken BEQZ
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 2, 0));
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 2, 2));
		prog.push_back(branch_instr(proc_pkg::op_bnez, 0, 4));
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 2, 4));
		prog.push_back(imm_instr(proc_pkg::op_addi, 0, 3, -1));
		prog.push_back(branch_instr(proc_pkg::op_bnez, 3, 4));
		// Shadow of the taken BNEZ
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 2, 6));
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 2, 8));
		prog.push_back(branch_instr(proc_pkg::op_beqz, 3, 4));
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 3, 10));
		prog.push_back(halt_instr());
		run_program();
		expect_store(16'd68, 16'h0005);
		expect_store(16'd74, 16'hffff);
		match_store_log();
		fill_intact(16'd64);
		fill_intact(16'd66);
		fill_intact(16'd70);
		fill_intact(16'd72);
		flag_equals("err", err, 1'b0);
	endtask

	task automatic halt_behavior();
		logic [31:0] r;
		int          v8;
		start_test("halt stops the program");
		r = next_rand();
		v8 = int'($signed(r[23:16]));
		prog.push_back(lbi_instr(7, 64));
		prog.push_back(lbi_instr(1, v8));
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 1, 0));
		prog.push_back(halt_instr());
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 1, 2));
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 1, 4));
		run_program();
		expect_store(16'd64, 16'(v8));
		match_store_log();
		fill_intact(16'd66);
		fill_intact(16'd68);
		flag_equals("halted", halted, 1'b1);
		flag_equals("err", err, 1'b0);
	endtask

	task automatic illegal_opcode();
		start_test("illegal opcode");
		prog.push_back(lbi_instr(7, 64));
		prog.push_back(16'hf800);
		prog.push_back(lbi_instr(1, 3));
		prog.push_back(imm_instr(proc_pkg::op_st, 7, 1, 0));
		prog.push_back(halt_instr());
		run_program();
		expect_store(16'd64, 16'h0003);
		match_store_log();
		flag_equals("err", err, 1'b1);
	endtask

	// Data port monitor sampled mid-cycle while the port is stable
	initial begin
		port_errors = 0;
		reset_prev = 1'b0;
		halted_q = 1'b0;
		forever begin
			@(negedge clk);
			if (reset && reset_prev) begin
				reset_state_is("imem_addr", imem_addr, 16'h0000);
				reset_state_is("dmem_en", {15'h0000, dmem_en}, 16'h0000);
				reset_state_is("dmem_wr", {15'h0000, dmem_wr}, 16'h0000);
				reset_state_is("halted", {15'h0000, halted}, 16'h0000);
				reset_state_is("err", {15'h0000, err}, 16'h0000);
			end else if (!reset) begin
				if (halted_q && halted !== 1'b1) begin
					port_errors++;
					$display("FAIL halted: expected 1, got %h", halted);
				end
				if (dmem_en && dmem_wr) begin
					if (halted) begin
						port_errors++;
						$display("Error: store at %h after the processor halted", dmem_addr);
					end
					log_addr.push_back(dmem_addr);
					log_data.push_back(dmem_wdata);
					dmem[dmem_addr[8:1]] = dmem_wdata;
				end
			end
			if (reset) begin
				halted_q = 1'b0;
			end else begin
				halted_q = halted;
			end
			reset_prev = reset;
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Error: run did not finish within %0d cycles", watchdog_cycles);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		restart = 1'b0;
		errors = 0;
		checks = 0;
		lcg_state = 32'hc543_7a09;
		for (int i = 0; i < 256; i++) begin
			imem[i[7:0]] = halt_instr();
			dmem[i[7:0]] = fill_word(i[7:0]);
		end
		while (reset !== 1'b0) @(negedge clk);
		alu_forwarding();
		immediate_extension();
		load_use_stall();
		branch_paths();
		halt_behavior();
		illegal_opcode();
		$display("Checks: %0d, errors: %0d, port errors: %0d", checks, errors, port_errors);
		if (errors == 0 && port_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/proc_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/reg_file.sv
src/execute_stage.sv
src/hazard_unit.sv
src/writeback_stage.sv
src/proc.sv
testbench/tb_clock_gen.sv
testbench/proc_tb.sv

// ==== Makefile ====
# Verilator build and run of the processor testbench

VERILATOR ?= verilator
TOP ?= proc_tb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= >>> PASS

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qxF '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
